/* source/spi_link_pkg.sv */
`default_nettype none

package spi_link_pkg;

	//////////////////////////////
	// Link defaults
	//////////////////////////////

	// Bits per transfer, shifted MSB first
	parameter int SPI_WORD_WIDTH = 32;

	// SCK half period is SPI_CLK_DIV+1 system cycles
	parameter int SPI_CLK_DIV = 1;

	//////////////////////////////
	// Master state encoding
	//////////////////////////////

	// IDLE    chip select high, waiting for a trigger
	// SELECT  chip select low, waiting for the first SCK rise
	// SHIFT   SCK running, one bit per period
	// FINISH  one cycle, done pulse and chip select back high
	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		SELECT = 2'd1,
		SHIFT  = 2'd2,
		FINISH = 2'd3
	} spi_state_t;

endpackage

`default_nettype wire

/* source/spi_clk_conditioner.sv */
`default_nettype none

module spi_clk_conditioner #(
	parameter int DIV = spi_link_pkg::SPI_CLK_DIV
) (
	input  logic CLK50MHZ,
	input  logic RST,
	output logic clk_hf,
	output logic clk_pos_trig,
	output logic clk_neg_trig
);

	// Counter wide enough to reach DIV, one bit minimum
	localparam int CNT_W = (DIV > 0) ? $clog2(DIV + 1) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DIV);

	logic [CNT_W-1:0] cnt;
	logic             terminal;

	//////////////////////////////
	// Half period counter
	//////////////////////////////

	// Terminal count ends each half period of clk_hf
	assign terminal = (cnt == CNT_LAST);

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			cnt <= '0;
		end else if (terminal) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + CNT_W'(1);
		end
	end

	//////////////////////////////
	// Square wave
	//////////////////////////////

	// Starts low after reset, toggles once per half period
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			clk_hf <= 1'b0;
		end else if (terminal) begin
			clk_hf <= ~clk_hf;
		end
	end

	//////////////////////////////
	// Edge strobes
	//////////////////////////////

	// Both strobes lead the edge of clk_hf by one system cycle
	// Low clk_hf at terminal count means a rising edge comes next
	assign clk_pos_trig = terminal & ~clk_hf;

	// High clk_hf at terminal count means a falling edge comes next
	assign clk_neg_trig = terminal & clk_hf;

endmodule

`default_nettype wire

/* source/spi_master.sv */
`default_nettype none

module spi_master #(
	parameter int WIDTH = spi_link_pkg::SPI_WORD_WIDTH,
	parameter int DIV   = spi_link_pkg::SPI_CLK_DIV
) (
	input  logic             CLK50MHZ,
	input  logic             RST,
	// SPI pins
	output logic             spi_sck,
	output logic             spi_cs,
	input  logic             spi_miso,
	output logic             spi_mosi,
	// User side
	input  logic [WIDTH-1:0] data_in,
	output logic [WIDTH-1:0] data_out,
	input  logic             spi_trig,
	output logic             spi_done,
	output logic             spi_busy
);

	import spi_link_pkg::*;

	// Bit counter has to hold the value WIDTH itself
	localparam int CNT_W = $clog2(WIDTH + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(WIDTH);

	logic             clk_hf;
	logic             clk_pos_trig;
	logic             clk_neg_trig;

	spi_state_t       state;
	spi_state_t       state_next;

	logic [WIDTH-1:0] shift_reg;
	logic [CNT_W-1:0] bit_cnt;

	logic             accept;
	logic             last_bit;
	logic             sample;
	logic             advance;

	//////////////////////////////
	// SCK generation
	//////////////////////////////

	spi_clk_conditioner #(
		.DIV(DIV)
	) spi_clk_conditioner_inst (
		.CLK50MHZ    (CLK50MHZ),
		.RST         (RST),
		.clk_hf      (clk_hf),
		.clk_pos_trig(clk_pos_trig),
		.clk_neg_trig(clk_neg_trig)
	);

	//////////////////////////////
	// Control decode
	//////////////////////////////

	// Trigger only counts while no transfer is running
	assign accept = spi_trig & ~spi_busy;

	// All WIDTH bits have been sampled
	assign last_bit = (bit_cnt == CNT_LAST);

	// MISO is taken at every rising edge until the word is full
	assign sample = clk_pos_trig & spi_busy & ~last_bit;

	// MOSI moves on the falling edges inside SHIFT only
	assign advance = clk_neg_trig & (state == SHIFT);

	//////////////////////////////
	// Transfer FSM
	//////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (accept)
					state_next = SELECT;
			end
			SELECT: begin
				// First rising edge starts the clock on the pin
				if (clk_pos_trig)
					state_next = SHIFT;
			end
			SHIFT: begin
				// Wait for the fall that ends the last bit period
				if (clk_neg_trig && last_bit)
					state_next = FINISH;
			end
			FINISH: begin
				// Busy is already low here, so a new trigger is taken
				if (accept)
					state_next = SELECT;
				else
					state_next = IDLE;
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	//////////////////////////////
	// Shift register and count
	//////////////////////////////

	// Word to send on entry, received word builds up from the LSB side
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			shift_reg <= '0;
			bit_cnt   <= '0;
		end else if (accept) begin
			shift_reg <= data_in;
			bit_cnt   <= '0;
		end else if (sample) begin
			shift_reg <= {shift_reg[WIDTH-2:0], spi_miso};
			bit_cnt   <= bit_cnt + CNT_W'(1);
		end
	end

	//////////////////////////////
	// MOSI
	//////////////////////////////

	// MSB goes out together with chip select
	// After each rise the next bit sits at the top of the shift register
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			spi_mosi <= 1'b0;
		end else if (accept) begin
			spi_mosi <= data_in[WIDTH-1];
		end else if (advance) begin
			if (last_bit)
				spi_mosi <= 1'b0;
			else
				spi_mosi <= shift_reg[WIDTH-1];
		end
	end

	//////////////////////////////
	// Outputs
	//////////////////////////////

	// Clock reaches the pin only in SHIFT, so it idles low
	assign spi_sck = (state == SHIFT) ? clk_hf : 1'b0;

	assign spi_busy = (state == SELECT) || (state == SHIFT);

	// Chip select is low exactly while busy
	assign spi_cs = ~spi_busy;

	assign spi_done = (state == FINISH);

	// Holds the received word from done until the next accepted trigger
	assign data_out = shift_reg;

endmodule

`default_nettype wire

/* source/spi_link_top.sv */
`default_nettype none

module spi_link_top #(
	parameter int WIDTH = spi_link_pkg::SPI_WORD_WIDTH,
	parameter int DIV   = spi_link_pkg::SPI_CLK_DIV
) (
	input  logic             CLK50MHZ,
	input  logic             RST,
	// SPI pins
	output logic             spi_sck,
	output logic             spi_cs,
	input  logic             spi_miso,
	output logic             spi_mosi,
	// User side
	input  logic [WIDTH-1:0] data_in,
	output logic [WIDTH-1:0] data_out,
	input  logic             spi_trig,
	output logic             spi_done,
	output logic             spi_busy
);

	//////////////////////////////
	// SPI master
	//////////////////////////////

	// Word width and divider come straight from this level
	spi_master #(
		.WIDTH(WIDTH),
		.DIV  (DIV)
	) spi_master_inst (
		.CLK50MHZ(CLK50MHZ),
		.RST     (RST),
		// Pin side
		.spi_sck (spi_sck),
		.spi_cs  (spi_cs),
		.spi_miso(spi_miso),
		.spi_mosi(spi_mosi),
		// User side
		.data_in (data_in),
		.data_out(data_out),
		.spi_trig(spi_trig),
		.spi_done(spi_done),
		.spi_busy(spi_busy)
	);

endmodule

`default_nettype wire

/* verification/spi_link_assertions.sv */
`default_nettype none

module spi_link_assertions #(
	parameter int WIDTH = spi_link_pkg::SPI_WORD_WIDTH
) (
	input logic                     CLK50MHZ,
	input logic                     RST,
	input logic                     spi_sck,
	input logic                     spi_cs,
	input logic                     spi_done,
	input logic                     spi_trig,
	input logic [WIDTH-1:0]         data_out,
	input spi_link_pkg::spi_state_t state
);

	timeunit 1ns;
	timeprecision 1ps;

	import spi_link_pkg::*;

	// Count of failed assertions
	int unsigned failures = 0;

	//////////////////////////////
	// Pin rules
	//////////////////////////////

	// SCK stays low outside a transfer
	sck_idle_low: assert property (@(posedge CLK50MHZ) disable iff (RST)
		spi_cs |-> !spi_sck)
		else begin
			failures++;
			$error("SCK is active while chip select is high");
		end

	// Done is a single cycle pulse
	done_one_cycle: assert property (@(posedge CLK50MHZ) disable iff (RST)
		spi_done |=> !spi_done)
		else begin
			failures++;
			$error("spi_done lasted more than one cycle");
		end

	// Done comes together with chip select going back high
	done_with_cs_rise: assert property (@(posedge CLK50MHZ) disable iff (RST)
		spi_done |-> $rose(spi_cs))
		else begin
			failures++;
			$error("spi_done without a rising chip select");
		end

	//////////////////////////////
	// FSM rule
	//////////////////////////////

	// No trigger means the FSM and the received word stay put
	idle_needs_trigger: assert property (@(posedge CLK50MHZ) disable iff (RST)
		(state == IDLE && !spi_trig) |=> (state == IDLE && $stable(data_out)))
		else begin
			failures++;
			$error("Master left IDLE without a trigger");
		end

endmodule

bind spi_master spi_link_assertions #(
	.WIDTH(WIDTH)
) spi_link_assertions_inst (
	.CLK50MHZ(CLK50MHZ),
	.RST     (RST),
	.spi_sck (spi_sck),
	.spi_cs  (spi_cs),
	.spi_done(spi_done),
	.spi_trig(spi_trig),
	.data_out(data_out),
	.state   (state)
);

`default_nettype wire

/* verification/spi_link_tb.sv */
`default_nettype none

module spi_link_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import spi_link_pkg::*;

	localparam int WIDTH = SPI_WORD_WIDTH;
	localparam int DIV   = SPI_CLK_DIV;
	// Chip select bound plus a few cycles of trigger latency
	localparam int DONE_TIMEOUT = 2 * (WIDTH + 1) * (DIV + 1) + 8;

	logic             CLK50MHZ;
	logic             RST;
	logic             spi_sck;
	logic             spi_cs;
	logic             spi_miso;
	logic             spi_mosi;
	logic [WIDTH-1:0] data_in;
	logic [WIDTH-1:0] data_out;
	logic             spi_trig;
	logic             spi_done;
	logic             spi_busy;

	// Slave model state
	logic [WIDTH-1:0] slave_word;
	logic [WIDTH-1:0] slave_rx;
	int               slave_rises;
	int               miso_idx;

	logic [31:0]      lcg_state;

	spi_link_top #(
		.WIDTH(WIDTH),
		.DIV  (DIV)
	) spi_link_top_inst (
		.CLK50MHZ(CLK50MHZ),
		.RST     (RST),
		.spi_sck (spi_sck),
		.spi_cs  (spi_cs),
		.spi_miso(spi_miso),
		.spi_mosi(spi_mosi),
		.data_in (data_in),
		.data_out(data_out),
		.spi_trig(spi_trig),
		.spi_done(spi_done),
		.spi_busy(spi_busy)
	);

	initial begin
		CLK50MHZ = 1'b0;
	end

	always #10 CLK50MHZ = ~CLK50MHZ;

	//////////////////////////////
	// SPI slave model, mode 0
	//////////////////////////////

	// MSB is ready as soon as chip select falls
	always @(negedge spi_cs) begin
		slave_rx    <= '0;
		slave_rises <= 0;
		miso_idx    <= WIDTH - 1;
		spi_miso    <= slave_word[WIDTH-1];
	end

	always @(negedge spi_sck) begin
		if (!spi_cs && miso_idx > 0) begin
			miso_idx <= miso_idx - 1;
			spi_miso <= slave_word[miso_idx-1];
		end
	end

	always @(posedge spi_sck) begin
		if (!spi_cs) begin
			slave_rx    <= {slave_rx[WIDTH-2:0], spi_mosi};
			slave_rises <= slave_rises + 1;
		end
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic logic [31:0] lcg_step(input logic [31:0] value);
		return value * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic random_word(output logic [WIDTH-1:0] word);
		lcg_state = lcg_step(lcg_state);
		word = WIDTH'(lcg_state);
	endtask

	task automatic check_value(input string name, input logic [WIDTH-1:0] got,
		input logic [WIDTH-1:0] expected);
		assert (got === expected) else begin
			$display("Test failed");
			$display("Fail %s: got %h, expected %h", name, got, expected);
			$fatal(1);
		end
	endtask

	// One cycle trigger pulse, slave reply loaded first
	task automatic start_transfer(input logic [WIDTH-1:0] word, input logic [WIDTH-1:0] reply);
		slave_word = reply;
		data_in  <= word;
		spi_trig <= 1'b1;
		@(posedge CLK50MHZ);
		spi_trig <= 1'b0;
	endtask

	task automatic wait_for_done();
		int   cycles;
		logic seen;
		cycles = 0;
		seen   = 1'b0;
		while (!seen && cycles < DONE_TIMEOUT) begin
			@(posedge CLK50MHZ);
			seen = spi_done;
			cycles++;
		end
		assert (seen) else begin
			$display("Test failed");
			$display("Timeout while waiting for spi_done after %0d cycles", DONE_TIMEOUT);
			$fatal(1);
		end
	endtask

	// Runs in the cycle of the done pulse
	task automatic check_transfer(input logic [WIDTH-1:0] word, input logic [WIDTH-1:0] reply);
		check_value("spi_cs", spi_cs, 1'b1);
		check_value("spi_busy", spi_busy, 1'b0);
		check_value("slave_rx", slave_rx, word);
		check_value("slave_rises", WIDTH'(slave_rises), WIDTH'(WIDTH));
		check_value("data_out", data_out, reply);
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////

	task automatic test_reset_state();
		@(posedge CLK50MHZ);
		check_value("spi_cs", spi_cs, 1'b1);
		check_value("spi_sck", spi_sck, 1'b0);
		check_value("spi_mosi", spi_mosi, 1'b0);
		check_value("spi_done", spi_done, 1'b0);
		check_value("spi_busy", spi_busy, 1'b0);
		check_value("data_out", data_out, '0);
	endtask

	task automatic test_single_transfer();
		logic [WIDTH-1:0] word;
		logic [WIDTH-1:0] reply;
		random_word(word);
		random_word(reply);
		start_transfer(word, reply);
		wait_for_done();
		check_transfer(word, reply);
	endtask

	task automatic test_back_to_back();
		logic [WIDTH-1:0] word;
		logic [WIDTH-1:0] reply;
		for (int i = 0; i < 10; i++) begin
			random_word(word);
			random_word(reply);
			start_transfer(word, reply);
			wait_for_done();
			check_transfer(word, reply);
		end
	endtask

	// Second trigger lands in the middle of the first transfer
	task automatic test_ignored_trigger();
		logic [WIDTH-1:0] first;
		logic [WIDTH-1:0] second;
		logic [WIDTH-1:0] reply;
		random_word(first);
		random_word(second);
		random_word(reply);
		start_transfer(first, reply);
		repeat (4) @(posedge CLK50MHZ);
		check_value("spi_busy", spi_busy, 1'b1);
		data_in  <= second;
		spi_trig <= 1'b1;
		@(posedge CLK50MHZ);
		spi_trig <= 1'b0;
		wait_for_done();
		check_transfer(first, reply);
		repeat (DONE_TIMEOUT) begin
			@(posedge CLK50MHZ);
			check_value("spi_done", spi_done, 1'b0);
			check_value("spi_cs", spi_cs, 1'b1);
		end
	endtask

	task automatic test_data_hold();
		logic [WIDTH-1:0] word;
		logic [WIDTH-1:0] reply;
		random_word(word);
		random_word(reply);
		start_transfer(word, reply);
		wait_for_done();
		check_transfer(word, reply);
		repeat (20) begin
			@(posedge CLK50MHZ);
			check_value("data_out", data_out, reply);
		end
	endtask

	initial begin
		int assert_failures;
		RST        = 1'b1;
		spi_trig   = 1'b0;
		data_in    = '0;
		spi_miso   = 1'b0;
		slave_word = '0;
		lcg_state  = 32'ha282;
		repeat (3) @(posedge CLK50MHZ);
		RST <= 1'b0;
		test_reset_state();
		test_single_transfer();
		test_back_to_back();
		test_ignored_trigger();
		test_data_hold();
		assert_failures = spi_link_top_inst.spi_master_inst.spi_link_assertions_inst.failures;
		if (assert_failures != 0) begin
			$display("Test failed");
			$display("Bound assertions failed %0d times during the run", assert_failures);
			$fatal(1);
		end else begin
			$display("Test passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* verilog.f */
source/spi_link_pkg.sv
source/spi_clk_conditioner.sv
source/spi_master.sv
source/spi_link_top.sv
verification/spi_link_assertions.sv
verification/spi_link_tb.sv

/* Bender.yml */
package:
  name: spi_link

sources:
  - source/spi_link_pkg.sv
  - source/spi_clk_conditioner.sv
  - source/spi_master.sv
  - source/spi_link_top.sv
  - target: test
    files:
      - verification/spi_link_assertions.sv
      - verification/spi_link_tb.sv
